/* logic/bus_settings.svh */
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// number of harts sharing the bus, each hart owns two requesters
`define BUS_NUM_HARTS 2

// requester 2h is the icache of hart h, 2h+1 its dcache
`define BUS_NUM_REQ (2 * `BUS_NUM_HARTS)

`define BUS_ADDR_W 32
`define BUS_WORD_W 32

// one enable bit per byte lane of a data word
`define BUS_BE_W (`BUS_WORD_W / 8)

`endif

/* logic/bus_types_pkg.sv */
`default_nettype none

`include "bus_settings.svh"

package bus_types_pkg;

    // ************************************************************
    // data path types shared by the caches and the memory side
    // ************************************************************

    typedef logic [`BUS_WORD_W-1:0] word_t;

    typedef logic [`BUS_ADDR_W-1:0] addr_t;

    // sized so every requester number fits
    typedef logic [$clog2(`BUS_NUM_REQ)-1:0] req_idx_t;

    // one memory command as seen by the bus, store data travels separately
    typedef struct packed {
        addr_t                 addr;
        logic                  write;   // set for a dwen request
        logic [`BUS_BE_W-1:0]  byte_en;
    } bus_cmd_t;

endpackage

`default_nettype wire

/* logic/coherence_pkg.sv */
`default_nettype none

`include "bus_settings.svh"

package coherence_pkg;

    // one state per cycle, ACCESS repeats while the memory is busy
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LATCH  = 2'd1,
        ACCESS = 2'd2,
        DONE   = 2'd3
    } ctrl_state_t;

    // bit r set means requester r drops its copy of the snooped line
    typedef logic [`BUS_NUM_REQ-1:0] inv_vec_t;

endpackage

`default_nettype wire

/* logic/bus_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module bus_ctrl_fsm (
    input  logic                         CLK,
    input  logic                         arst_n,
    input  logic [`BUS_NUM_REQ-1:0]      dren,
    input  logic [`BUS_NUM_REQ-1:0]      dwen,
    input  logic                         mem_busy,
    output bus_types_pkg::req_idx_t      grant_idx,
    output logic                         latch_en,
    output logic                         mem_ren,
    output logic                         mem_wen,
    output logic                         done,
    output logic [`BUS_NUM_REQ-1:0]      dwait
);

    localparam bus_types_pkg::req_idx_t last_req =
        bus_types_pkg::req_idx_t'(`BUS_NUM_REQ - 1);

    coherence_pkg::ctrl_state_t state;
    coherence_pkg::ctrl_state_t state_nxt;
    bus_types_pkg::req_idx_t    rr_ptr;
    bus_types_pkg::req_idx_t    pick;
    logic [`BUS_NUM_REQ-1:0]    pend;
    logic                       wr_q;

    assign pend = dren | dwen;

    // ************************************************************
    // round robin pick, the nearest pending requester at or after
    // the pointer wins
    // ************************************************************
    always_comb begin
        int cand;
        pick = rr_ptr;
        // walk from the far end so the closest candidate is written last
        for (int k = `BUS_NUM_REQ - 1; k >= 0; k--) begin
            cand = (int'(rr_ptr) + k) % `BUS_NUM_REQ;
            if (pend[cand]) begin
                pick = bus_types_pkg::req_idx_t'(cand);
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            coherence_pkg::IDLE:   if (|pend) state_nxt = coherence_pkg::LATCH;
            coherence_pkg::LATCH:  state_nxt = coherence_pkg::ACCESS;
            coherence_pkg::ACCESS: if (!mem_busy) state_nxt = coherence_pkg::DONE;
            default:               state_nxt = coherence_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= coherence_pkg::IDLE;
            rr_ptr    <= '0;
            grant_idx <= '0;
            wr_q      <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == coherence_pkg::IDLE && |pend) begin
                grant_idx <= pick;
            end
            if (state == coherence_pkg::LATCH) begin
                rr_ptr <= (grant_idx == last_req) ? '0 : grant_idx + 1'b1;
                wr_q   <= dwen[grant_idx];   // request is still held here
            end
        end
    end

    // ************************************************************
    // strobes
    // ************************************************************
    assign latch_en = (state == coherence_pkg::LATCH);
    assign mem_ren  = (state == coherence_pkg::ACCESS) && !wr_q;
    assign mem_wen  = (state == coherence_pkg::ACCESS) && wr_q;

    // marks the ACCESS cycle where the memory finishes, results show in DONE
    assign done = (state == coherence_pkg::ACCESS) && !mem_busy;

    always_comb begin
        dwait = '1;
        if (state == coherence_pkg::DONE) begin
            dwait[grant_idx] = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/grant_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module grant_capture #(
    parameter type payload_t = logic
) (
    input  logic                    CLK,
    input  logic                    arst_n,
    input  logic                    latch_en,
    input  bus_types_pkg::req_idx_t grant_idx,
    input  payload_t                req_in [`BUS_NUM_REQ],
    output payload_t                held
);

    payload_t sel;

    assign sel = req_in[grant_idx];  // granted requester's view of the payload

    // held stays put from one LATCH to the next, so the memory side sees
    // a steady value for the whole access
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            held <= '0;
        end else if (latch_en) begin
            held <= sel;
        end
    end

endmodule

`default_nettype wire

/* logic/load_return.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module load_return (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  logic                 mem_done,
    input  bus_types_pkg::word_t mem_rdata,
    input  logic                 mem_error,
    output bus_types_pkg::word_t dload,
    output logic                 derror
);

    // one result register shared by every requester, only the winner
    // looks at it while its dwait is low
    always_ff @(posedge CLK) begin
        if (mem_done) begin
            dload <= mem_rdata;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            derror <= 1'b0;
        end else if (mem_done) begin
            derror <= mem_error;   // also valid for writes
        end
    end

endmodule

`default_nettype wire

/* logic/snoop_inv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module snoop_inv (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  logic                        done,
    input  bus_types_pkg::req_idx_t     grant_idx,
    input  bus_types_pkg::bus_cmd_t     cmd,
    output coherence_pkg::inv_vec_t     ccinv,
    output bus_types_pkg::addr_t        ccsnoopaddr
);

    coherence_pkg::inv_vec_t targets;
    logic                    dcache_wr;

    // odd requester numbers are the data caches
    assign dcache_wr = done && cmd.write && grant_idx[0];

    always_comb begin
        targets = '0;
        for (int r = 1; r < `BUS_NUM_REQ; r += 2) begin
            if (bus_types_pkg::req_idx_t'(r) != grant_idx) begin
                targets[r] = 1'b1;
            end
        end
    end

    // done lasts one cycle, so the registered pulse lines up with DONE
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            ccinv <= '0;
        end else begin
            ccinv <= dcache_wr ? targets : '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (dcache_wr) begin
            ccsnoopaddr <= cmd.addr;   // kept until the next dcache write
        end
    end

endmodule

`default_nettype wire

/* logic/multicore_bus.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module multicore_bus (
    input  logic                        CLK,
    input  logic                        arst_n,
    // requester side, indexed by requester
    input  logic [`BUS_NUM_REQ-1:0]     dren,
    input  logic [`BUS_NUM_REQ-1:0]     dwen,
    input  bus_types_pkg::addr_t        daddr [`BUS_NUM_REQ],
    input  bus_types_pkg::word_t        dstore [`BUS_NUM_REQ],
    input  logic [`BUS_BE_W-1:0]        dbyte_en [`BUS_NUM_REQ],
    output logic [`BUS_NUM_REQ-1:0]     dwait,
    output bus_types_pkg::word_t        dload [`BUS_NUM_REQ],
    output logic [`BUS_NUM_REQ-1:0]     derror,
    output coherence_pkg::inv_vec_t     ccinv,
    output bus_types_pkg::addr_t        ccsnoopaddr [`BUS_NUM_REQ],
    // memory side
    output logic                        mem_ren,
    output logic                        mem_wen,
    output bus_types_pkg::addr_t        mem_addr,
    output bus_types_pkg::word_t        mem_wdata,
    output logic [`BUS_BE_W-1:0]        mem_byte_en,
    input  logic                        mem_busy,
    input  bus_types_pkg::word_t        mem_rdata,
    input  logic                        mem_error
);

    bus_types_pkg::req_idx_t grant_idx;
    logic                    latch_en;
    logic                    done;
    bus_types_pkg::bus_cmd_t req_cmd [`BUS_NUM_REQ];
    bus_types_pkg::bus_cmd_t held_cmd;
    bus_types_pkg::word_t    held_data;
    bus_types_pkg::word_t    load_word;
    logic                    load_err;
    bus_types_pkg::addr_t    snoop_addr;

    // ************************************************************
    // per requester packing and result fan out
    // ************************************************************
    for (genvar i = 0; i < `BUS_NUM_REQ; i++) begin : g_req
        assign req_cmd[i] = '{addr: daddr[i], write: dwen[i], byte_en: dbyte_en[i]};
        assign dload[i]       = load_word;
        assign derror[i]      = load_err;
        assign ccsnoopaddr[i] = snoop_addr;
    end

    bus_ctrl_fsm ctrl0 (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .dren      (dren),
        .dwen      (dwen),
        .mem_busy  (mem_busy),
        .grant_idx (grant_idx),
        .latch_en  (latch_en),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .done      (done),
        .dwait     (dwait)
    );

    grant_capture #(.payload_t(bus_types_pkg::bus_cmd_t)) cmd_cap0 (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .latch_en  (latch_en),
        .grant_idx (grant_idx),
        .req_in    (req_cmd),
        .held      (held_cmd)
    );

    grant_capture #(.payload_t(bus_types_pkg::word_t)) data_cap0 (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .latch_en  (latch_en),
        .grant_idx (grant_idx),
        .req_in    (dstore),
        .held      (held_data)
    );

    assign mem_addr    = held_cmd.addr;
    assign mem_byte_en = held_cmd.byte_en;
    assign mem_wdata   = held_data;

    load_return ret0 (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .mem_done  (done),
        .mem_rdata (mem_rdata),
        .mem_error (mem_error),
        .dload     (load_word),
        .derror    (load_err)
    );

    snoop_inv snoop0 (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .done        (done),
        .grant_idx   (grant_idx),
        .cmd         (held_cmd),
        .ccinv       (ccinv),
        .ccsnoopaddr (snoop_addr)
    );

endmodule

`default_nettype wire

/* dv/bus_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module bus_properties (
    input logic                    CLK,
    input logic                    arst_n,
    input logic [`BUS_NUM_REQ-1:0] dwait,
    input logic                    mem_ren,
    input logic                    mem_wen,
    input logic                    mem_busy,
    input bus_types_pkg::req_idx_t grant_idx
);

    // a completion belongs to one requester and follows the cycle the memory finished in
    one_completion: assert property (
        @(posedge CLK) disable iff (!arst_n)
            !(&dwait) |-> $onehot(~dwait) && $past((mem_ren || mem_wen) && !mem_busy)
    ) else $error("dwait low for more than one requester or without a finished access");

    // the strobes never overlap and hold still while the memory stalls
    strobes_exclusive: assert property (
        @(posedge CLK) disable iff (!arst_n)
            !(mem_ren && mem_wen)
            && (!$past(mem_busy && (mem_ren || mem_wen)) || $stable({mem_ren, mem_wen}))
    ) else $error("mem_ren and mem_wen overlapped or changed during a stall");

    icache_no_write: assert property (
        @(posedge CLK) disable iff (!arst_n) mem_wen |-> grant_idx[0]   // even index is an icache
    ) else $error("write strobe raised for instruction cache %0d", grant_idx);

endmodule

bind bus_ctrl_fsm bus_properties props0 (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .dwait     (dwait),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_busy  (mem_busy),
    .grant_idx (grant_idx)
);

`default_nettype wire

/* dv/multicore_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bus_settings.svh"

module multicore_bus_tb;

    localparam int NREQ      = `BUS_NUM_REQ;
    localparam int PERIOD    = 4;
    localparam int NTRANS    = 200;
    localparam int MEM_WORDS = 16;
    localparam int MAX_BUSY  = 3;                // also serves as a mask and must stay 2**n - 1
    localparam int LONGEST   = 4 + MAX_BUSY;     // idle, latch, access with stalls, done
    localparam int WATCHDOG  = (8 + 2 * NTRANS * LONGEST) * PERIOD;
    localparam bus_types_pkg::addr_t ERR_ADDR = 32'h0000_0034;

    logic                    CLK;
    logic                    arst_n;
    logic [NREQ-1:0]         dren;
    logic [NREQ-1:0]         dwen;
    logic [NREQ-1:0]         dwait;
    logic [NREQ-1:0]         derror;
    bus_types_pkg::addr_t    daddr [NREQ];
    bus_types_pkg::word_t    dstore [NREQ];
    logic [`BUS_BE_W-1:0]    dbyte_en [NREQ];
    bus_types_pkg::word_t    dload [NREQ];
    coherence_pkg::inv_vec_t ccinv;
    bus_types_pkg::addr_t    ccsnoopaddr [NREQ];
    logic                    mem_ren;
    logic                    mem_wen;
    bus_types_pkg::addr_t    mem_addr;
    bus_types_pkg::word_t    mem_wdata;
    logic [`BUS_BE_W-1:0]    mem_byte_en;
    logic                    mem_busy;
    bus_types_pkg::word_t    mem_rdata;
    logic                    mem_error;

    bus_types_pkg::word_t    mem_model [MEM_WORDS];
    bus_types_pkg::word_t    ref_mem [MEM_WORDS];
    integer                  seed = 32'h4b8d;
    logic                    run = 1'b0;
    int                      issued = 0;
    int                      completed = 0;

    multicore_bus dut0 (.*);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // ************************************************************
    // helpers and the reference model
    // ************************************************************
    function automatic int word_at(input bus_types_pkg::addr_t a);
        return int'(a[5:2]);
    endfunction

    // every bit of the byte address feeds the pattern
    function automatic bus_types_pkg::word_t fill_word(input int idx);
        return ((idx * 4) * 32'h9E37_79B9) ^ 32'hC001_D00D;
    endfunction

    function automatic bus_types_pkg::word_t merge_bytes(input bus_types_pkg::word_t old_w,
                                                         input bus_types_pkg::word_t new_w,
                                                         input logic [`BUS_BE_W-1:0] be);
        bus_types_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < `BUS_BE_W; b++) begin
            if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // winner is the first pending requester at or after the pointer
    function automatic void predict_completion(input logic [NREQ-1:0] pend, input int ptr,
                                               output int win,
                                               output coherence_pkg::inv_vec_t inv,
                                               output bus_types_pkg::word_t word,
                                               output logic err);
        win = -1;
        for (int k = 0; k < NREQ; k++) begin
            if (win < 0 && pend[(ptr + k) % NREQ]) win = (ptr + k) % NREQ;
        end
        err  = (daddr[win] == ERR_ADDR);
        word = ref_mem[word_at(daddr[win])];
        inv  = '0;
        if (dwen[win] && win % 2 == 1) begin
            for (int r = 1; r < NREQ; r += 2) inv[r] = (r != win);
        end
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input bus_types_pkg::word_t got,
                               input bus_types_pkg::word_t exp);
        assert (got === exp) else begin
            abort_run($sformatf("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // new access from cache r where only the data caches ever write
    task automatic issue_request(input int r);
        bus_types_pkg::word_t rnd;
        rnd         = $random(seed);
        daddr[r]    = bus_types_pkg::addr_t'(rnd[3:0]) << 2;
        dbyte_en[r] = (rnd[7:4] == '0) ? '1 : rnd[7:4];
        dstore[r]   = $random(seed);
        if (r % 2 == 1 && rnd[8]) dwen[r] = 1'b1;
        else dren[r] = 1'b1;
        issued++;
    endtask

    // ************************************************************
    // cache and memory models
    // ************************************************************
    initial begin : caches
        logic [NREQ-1:0] ended;
        logic            burst;
        dren  = '0;
        dwen  = '0;
        burst = 1'b1;   // all requesters raise together on the first cycle
        for (int r = 0; r < NREQ; r++) begin
            daddr[r]    = '0;
            dstore[r]   = '0;
            dbyte_en[r] = '0;
        end
        forever begin
            @(posedge CLK);
            ended = (dren | dwen) & ~dwait;
            #1;
            for (int r = 0; r < NREQ; r++) begin
                if (ended[r]) begin
                    dren[r] = 1'b0;
                    dwen[r] = 1'b0;
                end else if (run && !(dren[r] || dwen[r]) && issued < NTRANS
                             && (burst || ($random(seed) & 3) == 0)) begin
                    issue_request(r);
                end
            end
            burst = burst && !run;
        end
    end

    initial begin : memory
        int busy_left;
        for (int a = 0; a < MEM_WORDS; a++) mem_model[a] = fill_word(a);
        busy_left = 0;
        mem_busy  = 1'b0;
        mem_rdata = '0;
        mem_error = 1'b0;
        forever begin
            @(posedge CLK);
            if ((mem_ren || mem_wen) && busy_left > 0) begin
                busy_left--;
            end else if (mem_ren || mem_wen) begin
                if (mem_wen && mem_addr != ERR_ADDR) begin   // a failing write leaves memory alone
                    mem_model[word_at(mem_addr)] =
                        merge_bytes(mem_model[word_at(mem_addr)], mem_wdata, mem_byte_en);
                end
                busy_left = $random(seed) & MAX_BUSY;   // stall length of the next access
            end
            #1;
            mem_busy  = (busy_left > 0);
            mem_rdata = mem_model[word_at(mem_addr)];
            mem_error = (mem_addr == ERR_ADDR);
        end
    end

    // ************************************************************
    // comparison against the reference at every completion
    // ************************************************************
    initial begin : compare
        logic [NREQ-1:0]         arb_pend;
        logic [NREQ-1:0]         exp_wait;
        logic                    bus_free;
        logic                    err;
        int                      ptr;
        int                      w;
        coherence_pkg::inv_vec_t inv;
        bus_types_pkg::word_t    word;
        arb_pend = '0;
        bus_free = 1'b1;
        ptr      = 0;
        for (int a = 0; a < MEM_WORDS; a++) ref_mem[a] = fill_word(a);
        forever begin
            @(negedge CLK);
            if (bus_free && |(dren | dwen)) begin
                arb_pend = dren | dwen;   // the controller arbitrates on this set in IDLE
                bus_free = 1'b0;
            end
            if (&dwait) begin
                check_value("ccinv", bus_types_pkg::word_t'(ccinv), '0);
            end else begin
                assert (!bus_free) else abort_run("dwait went low with no request granted");
                predict_completion(arb_pend, ptr, w, inv, word, err);
                exp_wait    = '1;
                exp_wait[w] = 1'b0;
                check_value("dwait", bus_types_pkg::word_t'(dwait),
                            bus_types_pkg::word_t'(exp_wait));
                check_value("derror", bus_types_pkg::word_t'(derror[w]),
                            bus_types_pkg::word_t'(err));
                check_value("ccinv", bus_types_pkg::word_t'(ccinv), bus_types_pkg::word_t'(inv));
                if (dwen[w]) begin
                    for (int r = 0; r < NREQ; r++) begin
                        if (inv[r]) check_value("ccsnoopaddr", ccsnoopaddr[r], daddr[w]);
                    end
                    if (!err) begin
                        ref_mem[word_at(daddr[w])] =
                            merge_bytes(ref_mem[word_at(daddr[w])], dstore[w], dbyte_en[w]);
                    end
                end else begin
                    check_value("dload", dload[w], word);
                end
                ptr      = (w + 1) % NREQ;
                bus_free = 1'b1;
                completed++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG);
        abort_run($sformatf("timeout, only %0d of %0d transactions completed", completed, NTRANS));
    end

    initial begin : main
        arst_n = 1'b0;
        repeat (7) @(posedge CLK);
        @(negedge CLK);
        assert (&dwait && !mem_ren && !mem_wen && ccinv == '0)
            else abort_run("outputs are not at their reset values while reset is held");
        @(posedge CLK);
        #1 arst_n = 1'b1;
        @(negedge CLK);
        run = 1'b1;
        wait (completed == NTRANS);
        @(negedge CLK);
        assert (issued == NTRANS && (dren | dwen) == '0 && &dwait) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run("requests are still open after the last completion");
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
logic/bus_types_pkg.sv
logic/coherence_pkg.sv
logic/bus_ctrl_fsm.sv
logic/grant_capture.sv
logic/load_return.sv
logic/snoop_inv.sv
logic/multicore_bus.sv
dv/bus_properties.sv
dv/multicore_bus_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= multicore_bus_tb
RTL_TOP    ?= multicore_bus
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
